/* common/eth_pkg.sv */
package eth_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam int          ETH_HDR_BYTES  = 14;
    localparam int          IPV4_HDR_BYTES = 20;   // no options
    localparam int          UDP_HDR_BYTES  = 8;

    localparam byte_t       IPV4_VER_IHL   = 8'h45;  // v4, 5 words
    localparam byte_t       IPV4_TTL       = 8'd64;
    localparam byte_t       IPV4_PROTO_UDP = 8'd17;
    localparam mac_addr_t   BROADCAST_MAC  = 48'hffff_ffff_ffff;

    // ones-complement sum over the header words, ID/flags/TOS are zero
    function automatic logic [15:0] ipv4_hdr_csum(input logic [15:0] total_len,
                                                  input ip_addr_t    src_ip,
                                                  input ip_addr_t    dst_ip);
        logic [31:0] sum;
        sum = {16'h0000, IPV4_VER_IHL, 8'h00} + {16'h0000, total_len}
            + {16'h0000, IPV4_TTL, IPV4_PROTO_UDP}
            + {16'h0000, src_ip[31:16]} + {16'h0000, src_ip[15:0]}
            + {16'h0000, dst_ip[31:16]} + {16'h0000, dst_ip[15:0]};
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};  // fold carries
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        return ~sum[15:0];
    endfunction

endpackage

/* common/stream_pkg.sv */
package stream_pkg;

    localparam eth_pkg::mac_addr_t LOCAL_MAC  = 48'h02_00_00_00_00_02;
    localparam eth_pkg::ip_addr_t  LOCAL_IP   = {8'd10, 8'd0, 8'd0, 8'd2};
    localparam eth_pkg::ip_addr_t  HOST_IP    = {8'd10, 8'd0, 8'd0, 8'd1};
    localparam eth_pkg::udp_port_t RB_TX_PORT = 16'd10001;  // host listens here
    localparam eth_pkg::udp_port_t VC_TX_PORT = 16'd40001;

    localparam int SEQ_NUM_BYTES = 4;
    typedef logic [8*SEQ_NUM_BYTES-1:0] seq_num_t;

    localparam int PAYLOAD_BYTES = 16;
    localparam int HDR_BYTES     = eth_pkg::ETH_HDR_BYTES + eth_pkg::IPV4_HDR_BYTES
                                 + eth_pkg::UDP_HDR_BYTES + SEQ_NUM_BYTES;   // 46
    localparam int FRAME_BYTES   = HDR_BYTES + PAYLOAD_BYTES;                 // 62

    localparam logic [15:0] UDP_LEN        = 16'(eth_pkg::UDP_HDR_BYTES + SEQ_NUM_BYTES
                                                 + PAYLOAD_BYTES);
    localparam logic [15:0] IPV4_TOTAL_LEN = 16'(eth_pkg::IPV4_HDR_BYTES) + UDP_LEN;

    localparam int FRAME_BUFFERS = 2;
    localparam int FIFO_DEPTH    = 2 ** $clog2(FRAME_BUFFERS * FRAME_BYTES);  // 128

    typedef logic [$clog2(FIFO_DEPTH):0]    fifo_cnt_t;
    typedef logic [$clog2(FRAME_BUFFERS):0] frame_cnt_t;
    typedef logic [31:0]                    cntr_t;
    typedef logic [$clog2(HDR_BYTES)-1:0]   hdr_idx_t;
    typedef logic [$clog2(PAYLOAD_BYTES)-1:0] pay_idx_t;

    localparam int NUM_SOURCES = 2;
    localparam int SRC_RB      = 0;
    localparam int SRC_VC      = 1;
    typedef logic [$clog2(NUM_SOURCES)-1:0] src_idx_t;

    // every covered field is fixed, so this folds to a constant
    localparam logic [15:0] IPV4_HDR_CSUM =
        eth_pkg::ipv4_hdr_csum(IPV4_TOTAL_LEN, LOCAL_IP, HOST_IP);

    typedef enum logic {ARB_IDLE, ARB_SEND} arb_state_t;
    typedef enum logic [1:0] {PK_IDLE, PK_HDR, PK_PAYLOAD} pktzr_state_t;

endpackage

/* udp_tx/udp_header_gen.sv */
`timescale 1ns/10ps

module udp_header_gen #(
    parameter eth_pkg::udp_port_t P_DEST_PORT = '0
) (
    input  stream_pkg::hdr_idx_t i_index,
    input  stream_pkg::seq_num_t i_seq_num,
    output eth_pkg::byte_t       o_hdr_byte
);
    import eth_pkg::*;
    import stream_pkg::*;

    udp_port_t                 src_port;
    seq_num_t                  seq_le;
    logic [8*HDR_BYTES-1:0]    hdr;    // first byte on the wire in the top bits

    assign src_port = P_DEST_PORT + 16'd1;
    assign seq_le   = {i_seq_num[7:0], i_seq_num[15:8], i_seq_num[23:16], i_seq_num[31:24]};

    assign hdr = {
        // ethernet II
        BROADCAST_MAC,
        LOCAL_MAC,
        ETHERTYPE_IPV4,
        // ipv4
        IPV4_VER_IHL,
        8'h00,             // tos
        IPV4_TOTAL_LEN,
        16'h0000,          // id
        16'h0000,          // flags, frag offset
        IPV4_TTL,
        IPV4_PROTO_UDP,
        IPV4_HDR_CSUM,
        LOCAL_IP,
        HOST_IP,
        // udp
        src_port,
        P_DEST_PORT,
        UDP_LEN,
        16'h0000,          // udp checksum unused
        // sequence number, lsb first
        seq_le
    };

    assign o_hdr_byte = (int'(i_index) < HDR_BYTES) ?
                        hdr[(HDR_BYTES - 1 - int'(i_index)) * 8 +: 8] : '0;

endmodule

/* verilog/frame_fifo.sv */
`timescale 1ns/10ps

module frame_fifo (
    input  logic           i_tx_clk125,
    input  logic           i_reset,
    input  logic           i_wr,
    input  eth_pkg::byte_t i_wr_byte,
    input  logic           i_wr_last,
    input  logic           i_rd,
    output eth_pkg::byte_t o_rd_byte,
    output logic           o_rd_last,
    output logic           o_frame_avail,
    output logic           o_room
);
    import eth_pkg::*;
    import stream_pkg::*;

    byte_t                        mem      [FIFO_DEPTH];
    logic                         last_mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    fifo_cnt_t                    fill_cnt;
    frame_cnt_t                   frame_cnt;   // complete frames held

    assign o_rd_byte     = mem[rd_ptr];        // head shows without a read
    assign o_rd_last     = last_mem[rd_ptr];
    assign o_frame_avail = (frame_cnt != '0);
    assign o_room        = (fill_cnt <= fifo_cnt_t'(FIFO_DEPTH - FRAME_BYTES));

    always_ff @(posedge i_tx_clk125) begin
        if (i_wr) begin
            mem[wr_ptr]      <= i_wr_byte;
            last_mem[wr_ptr] <= i_wr_last;
        end
    end

    always_ff @(posedge i_tx_clk125) begin
        if (i_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill_cnt  <= '0;
            frame_cnt <= '0;
        end else begin
            if (i_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_rd)
                rd_ptr <= rd_ptr + 1'b1;
            fill_cnt  <= fill_cnt + fifo_cnt_t'(i_wr) - fifo_cnt_t'(i_rd);
            frame_cnt <= frame_cnt + frame_cnt_t'(i_wr && i_wr_last)
                                   - frame_cnt_t'(i_rd && o_rd_last);
        end
    end

endmodule

/* udp_tx/udp_packetizer.sv */
`timescale 1ns/10ps

module udp_packetizer #(
    parameter eth_pkg::udp_port_t P_DEST_PORT = '0
) (
    input  logic              i_tx_clk125,
    input  logic              i_reset,
    input  logic              i_start,
    output logic              o_start_ack,
    output logic              o_done,
    input  logic              i_data_byte_vld,
    input  eth_pkg::byte_t    i_data_byte,
    output logic              o_data_byte_rd,
    output stream_pkg::cntr_t o_overflow_cntr,
    output logic              o_frame_avail,
    output eth_pkg::byte_t    o_frame_byte,
    output logic              o_frame_last,
    input  logic              i_frame_rd
);
    import eth_pkg::*;
    import stream_pkg::*;

    pktzr_state_t state;
    hdr_idx_t     hdr_idx;
    pay_idx_t     pay_idx;
    seq_num_t     seq_num;     // next number to hand out
    seq_num_t     frame_seq;   // number of the frame being built
    byte_t        hdr_byte;
    byte_t        fifo_wr_byte;
    logic         fifo_wr;
    logic         take_last;
    logic         room;

    udp_header_gen #(.P_DEST_PORT(P_DEST_PORT)) udp_header_gen_i (
        .i_index    (hdr_idx),
        .i_seq_num  (frame_seq),
        .o_hdr_byte (hdr_byte)
    );

    assign o_data_byte_rd = (state == PK_PAYLOAD) && i_data_byte_vld;
    assign take_last      = o_data_byte_rd && (pay_idx == pay_idx_t'(PAYLOAD_BYTES - 1));
    assign fifo_wr        = (state == PK_HDR) || o_data_byte_rd;
    assign fifo_wr_byte   = (state == PK_HDR) ? hdr_byte : i_data_byte;

    always_ff @(posedge i_tx_clk125) begin
        if (i_reset) begin
            state           <= PK_IDLE;
            hdr_idx         <= '0;
            pay_idx         <= '0;
            seq_num         <= '0;
            o_start_ack     <= 1'b0;
            o_done          <= 1'b0;
            o_overflow_cntr <= '0;
        end else begin
            o_start_ack <= 1'b0;
            o_done      <= take_last;
            case (state)
                PK_IDLE: begin
                    hdr_idx <= '0;
                    pay_idx <= '0;
                    if (i_start && room) begin
                        o_start_ack <= 1'b1;
                        seq_num     <= seq_num + 1'b1;
                        state       <= PK_HDR;
                    end else if (i_start) begin
                        o_overflow_cntr <= o_overflow_cntr + 1'b1;  // refused, no room
                    end
                end
                PK_HDR: begin
                    hdr_idx <= hdr_idx + 1'b1;
                    if (hdr_idx == hdr_idx_t'(HDR_BYTES - 1))
                        state <= PK_PAYLOAD;
                end
                PK_PAYLOAD: begin
                    if (o_data_byte_rd)
                        pay_idx <= pay_idx + 1'b1;
                    if (take_last)
                        state <= PK_IDLE;
                end
                default: state <= PK_IDLE;
            endcase
        end
    end

    // follows seq_num while idle, frozen from the ack on
    always_ff @(posedge i_tx_clk125) begin
        if (state == PK_IDLE)
            frame_seq <= seq_num;
    end

    frame_fifo frame_fifo_i (
        .i_tx_clk125   (i_tx_clk125),
        .i_reset       (i_reset),
        .i_wr          (fifo_wr),
        .i_wr_byte     (fifo_wr_byte),
        .i_wr_last     (take_last),
        .i_rd          (i_frame_rd),
        .o_rd_byte     (o_frame_byte),
        .o_rd_last     (o_frame_last),
        .o_frame_avail (o_frame_avail),
        .o_room        (room)
    );

endmodule

/* mac_tx/mac_tx_arbiter.sv */
`timescale 1ns/10ps

module mac_tx_arbiter (
    input  logic                                           i_tx_clk125,
    input  logic                                           i_reset,
    input  logic [stream_pkg::NUM_SOURCES-1:0]             i_frame_avail,
    input  eth_pkg::byte_t [stream_pkg::NUM_SOURCES-1:0]   i_frame_byte,
    input  logic [stream_pkg::NUM_SOURCES-1:0]             i_frame_last,
    output logic [stream_pkg::NUM_SOURCES-1:0]             o_frame_rd,
    input  logic                                           i_mac_tx_macread,
    output eth_pkg::byte_t                                 o_mac_tx_fifodata,
    output logic                                           o_mac_tx_fifoavail,
    output logic                                           o_mac_tx_fifoeof
);
    import stream_pkg::*;

    arb_state_t state;
    src_idx_t   grant;       // last granted, the active one while sending
    src_idx_t   next_grant;
    logic       found;

    // round robin search, starts one past the last grant
    always_comb begin
        int cand;
        next_grant = grant;
        found      = 1'b0;
        for (int k = 1; k <= NUM_SOURCES; k++) begin
            cand = (int'(grant) + k) % NUM_SOURCES;
            if (!found && i_frame_avail[cand]) begin
                next_grant = src_idx_t'(cand);
                found      = 1'b1;
            end
        end
    end

    assign o_mac_tx_fifoavail = (state == ARB_SEND);
    assign o_mac_tx_fifodata  = i_frame_byte[grant];
    assign o_mac_tx_fifoeof   = o_mac_tx_fifoavail && i_frame_last[grant];

    // only the granted source sees the mac's read strobe
    always_comb begin
        o_frame_rd        = '0;
        o_frame_rd[grant] = o_mac_tx_fifoavail && i_mac_tx_macread;
    end

    always_ff @(posedge i_tx_clk125) begin
        if (i_reset) begin
            state <= ARB_IDLE;
            grant <= src_idx_t'(NUM_SOURCES - 1);  // so source 0 goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant <= next_grant;
                        state <= ARB_SEND;
                    end
                end
                ARB_SEND: begin
                    if (i_mac_tx_macread && o_mac_tx_fifoeof)
                        state <= ARB_IDLE;   // frame done
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

/* verilog/eth_tx_top.sv */
`timescale 1ns/10ps

module eth_tx_top (
    input  logic              i_tx_clk125,
    input  logic              i_reset,

    input  logic              i_rb_pktzr_start,
    output logic              o_rb_pktzr_start_ack,
    output logic              o_rb_pktzr_done,
    input  logic              i_rb_pktzr_data_byte_vld,
    input  eth_pkg::byte_t    i_rb_pktzr_data_byte,
    output logic              o_rb_pktzr_data_byte_rd,
    output stream_pkg::cntr_t o_rb_out_buf_overflow_cntr,

    input  logic              i_vc_pktzr_start,
    output logic              o_vc_pktzr_start_ack,
    output logic              o_vc_pktzr_done,
    input  logic              i_vc_pktzr_data_byte_vld,
    input  eth_pkg::byte_t    i_vc_pktzr_data_byte,
    output logic              o_vc_pktzr_data_byte_rd,
    output stream_pkg::cntr_t o_vc_out_buf_overflow_cntr,

    output eth_pkg::byte_t    o_mac_tx_fifodata,
    output logic              o_mac_tx_fifoavail,
    output logic              o_mac_tx_fifoeof,
    input  logic              i_mac_tx_macread
);
    import eth_pkg::*;
    import stream_pkg::*;

    // one lane per source, indexed by SRC_*
    logic  [NUM_SOURCES-1:0] frame_avail;
    logic  [NUM_SOURCES-1:0] frame_last;
    logic  [NUM_SOURCES-1:0] frame_rd;
    byte_t [NUM_SOURCES-1:0] frame_byte;

    udp_packetizer #(.P_DEST_PORT(RB_TX_PORT)) udp_packetizer_rb (
        .i_tx_clk125     (i_tx_clk125),
        .i_reset         (i_reset),
        .i_start         (i_rb_pktzr_start),
        .o_start_ack     (o_rb_pktzr_start_ack),
        .o_done          (o_rb_pktzr_done),
        .i_data_byte_vld (i_rb_pktzr_data_byte_vld),
        .i_data_byte     (i_rb_pktzr_data_byte),
        .o_data_byte_rd  (o_rb_pktzr_data_byte_rd),
        .o_overflow_cntr (o_rb_out_buf_overflow_cntr),
        .o_frame_avail   (frame_avail[SRC_RB]),
        .o_frame_byte    (frame_byte[SRC_RB]),
        .o_frame_last    (frame_last[SRC_RB]),
        .i_frame_rd      (frame_rd[SRC_RB])
    );

    udp_packetizer #(.P_DEST_PORT(VC_TX_PORT)) udp_packetizer_vc (
        .i_tx_clk125     (i_tx_clk125),
        .i_reset         (i_reset),
        .i_start         (i_vc_pktzr_start),
        .o_start_ack     (o_vc_pktzr_start_ack),
        .o_done          (o_vc_pktzr_done),
        .i_data_byte_vld (i_vc_pktzr_data_byte_vld),
        .i_data_byte     (i_vc_pktzr_data_byte),
        .o_data_byte_rd  (o_vc_pktzr_data_byte_rd),
        .o_overflow_cntr (o_vc_out_buf_overflow_cntr),
        .o_frame_avail   (frame_avail[SRC_VC]),
        .o_frame_byte    (frame_byte[SRC_VC]),
        .o_frame_last    (frame_last[SRC_VC]),
        .i_frame_rd      (frame_rd[SRC_VC])
    );

    mac_tx_arbiter mac_tx_arbiter_i (
        .i_tx_clk125        (i_tx_clk125),
        .i_reset            (i_reset),
        .i_frame_avail      (frame_avail),
        .i_frame_byte       (frame_byte),
        .i_frame_last       (frame_last),
        .o_frame_rd         (frame_rd),
        .i_mac_tx_macread   (i_mac_tx_macread),
        .o_mac_tx_fifodata  (o_mac_tx_fifodata),
        .o_mac_tx_fifoavail (o_mac_tx_fifoavail),
        .o_mac_tx_fifoeof   (o_mac_tx_fifoeof)
    );

endmodule

/* tb/eth_tx_assert.sv */
`timescale 1ns/10ps

module eth_tx_assert (
    input logic i_tx_clk125,
    input logic i_reset,
    input logic i_rb_pktzr_data_byte_vld,
    input logic i_vc_pktzr_data_byte_vld,
    input logic o_rb_pktzr_start_ack,
    input logic o_vc_pktzr_start_ack,
    input logic o_rb_pktzr_data_byte_rd,
    input logic o_vc_pktzr_data_byte_rd,
    input logic o_mac_tx_fifoavail,
    input logic o_mac_tx_fifoeof
);
    int unsigned fail_cnt = 0;   // polled by the testbench

    eof_needs_avail: assert property (@(posedge i_tx_clk125) disable iff (i_reset)
        o_mac_tx_fifoeof |-> o_mac_tx_fifoavail)
        else begin
            fail_cnt++;
            $error("fifoeof high while fifoavail is low");
        end

    // ack is a pulse, never two cycles in a row
    rb_ack_pulse: assert property (@(posedge i_tx_clk125) disable iff (i_reset)
        o_rb_pktzr_start_ack |=> !o_rb_pktzr_start_ack)
        else begin
            fail_cnt++;
            $error("rb start_ack longer than one cycle");
        end

    vc_ack_pulse: assert property (@(posedge i_tx_clk125) disable iff (i_reset)
        o_vc_pktzr_start_ack |=> !o_vc_pktzr_start_ack)
        else begin
            fail_cnt++;
            $error("vc start_ack longer than one cycle");
        end

    rb_rd_in_vld: assert property (@(posedge i_tx_clk125) disable iff (i_reset)
        o_rb_pktzr_data_byte_rd |-> i_rb_pktzr_data_byte_vld)
        else begin
            fail_cnt++;
            $error("rb data_byte_rd high without data_byte_vld");
        end

    vc_rd_in_vld: assert property (@(posedge i_tx_clk125) disable iff (i_reset)
        o_vc_pktzr_data_byte_rd |-> i_vc_pktzr_data_byte_vld)
        else begin
            fail_cnt++;
            $error("vc data_byte_rd high without data_byte_vld");
        end

endmodule

bind eth_tx_top eth_tx_assert eth_tx_assert_i (
    .i_tx_clk125              (i_tx_clk125),
    .i_reset                  (i_reset),
    .i_rb_pktzr_data_byte_vld (i_rb_pktzr_data_byte_vld),
    .i_vc_pktzr_data_byte_vld (i_vc_pktzr_data_byte_vld),
    .o_rb_pktzr_start_ack     (o_rb_pktzr_start_ack),
    .o_vc_pktzr_start_ack     (o_vc_pktzr_start_ack),
    .o_rb_pktzr_data_byte_rd  (o_rb_pktzr_data_byte_rd),
    .o_vc_pktzr_data_byte_rd  (o_vc_pktzr_data_byte_rd),
    .o_mac_tx_fifoavail       (o_mac_tx_fifoavail),
    .o_mac_tx_fifoeof         (o_mac_tx_fifoeof)
);

/* tb/eth_tx_tb.sv */
`timescale 1ns/10ps

module eth_tx_tb;
    import eth_pkg::*;
    import stream_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                   i_tx_clk125;
    logic                   i_reset;
    logic [NUM_SOURCES-1:0] start;
    logic [NUM_SOURCES-1:0] vld;
    byte_t                  data      [NUM_SOURCES];
    logic                   i_mac_tx_macread;
    logic [NUM_SOURCES-1:0] start_ack;
    logic [NUM_SOURCES-1:0] done;
    logic [NUM_SOURCES-1:0] data_rd;
    cntr_t                  ovf_cntr  [NUM_SOURCES];
    byte_t                  fifodata;
    logic                   fifoavail;
    logic                   fifoeof;

    integer   seed;
    string    test_name;
    byte_t    sent_q      [NUM_SOURCES][$];   // payload bytes taken per source
    seq_num_t exp_seq     [NUM_SOURCES];
    cntr_t    exp_ovf     [NUM_SOURCES];
    int       src_order   [$];                // source of each received frame
    byte_t    rx_frame    [$];
    byte_t    exp_frame   [FRAME_BYTES];

    eth_tx_top eth_tx_top_i (
        .i_tx_clk125                (i_tx_clk125),
        .i_reset                    (i_reset),
        .i_rb_pktzr_start           (start[SRC_RB]),
        .o_rb_pktzr_start_ack       (start_ack[SRC_RB]),
        .o_rb_pktzr_done            (done[SRC_RB]),
        .i_rb_pktzr_data_byte_vld   (vld[SRC_RB]),
        .i_rb_pktzr_data_byte       (data[SRC_RB]),
        .o_rb_pktzr_data_byte_rd    (data_rd[SRC_RB]),
        .o_rb_out_buf_overflow_cntr (ovf_cntr[SRC_RB]),
        .i_vc_pktzr_start           (start[SRC_VC]),
        .o_vc_pktzr_start_ack       (start_ack[SRC_VC]),
        .o_vc_pktzr_done            (done[SRC_VC]),
        .i_vc_pktzr_data_byte_vld   (vld[SRC_VC]),
        .i_vc_pktzr_data_byte       (data[SRC_VC]),
        .o_vc_pktzr_data_byte_rd    (data_rd[SRC_VC]),
        .o_vc_out_buf_overflow_cntr (ovf_cntr[SRC_VC]),
        .o_mac_tx_fifodata          (fifodata),
        .o_mac_tx_fifoavail         (fifoavail),
        .o_mac_tx_fifoeof           (fifoeof),
        .i_mac_tx_macread           (i_mac_tx_macread)
    );

    initial begin
        i_tx_clk125 = 1'b0;
        forever #20 i_tx_clk125 = ~i_tx_clk125;
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("** Error: %s: %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, exp_val, act_val);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error in %s: %s", test_name, what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic string src_name(input int src);
        return (src == SRC_RB) ? "rb" : "vc";
    endfunction

    // reference frame from the header rules plus the recorded payload
    task automatic build_expected(input int src, input seq_num_t seq);
        udp_port_t   dport;
        mac_addr_t   mac;
        logic [31:0] sum;
        int          k;
        dport = (src == SRC_RB) ? RB_TX_PORT : VC_TX_PORT;
        mac   = LOCAL_MAC;
        for (k = 0; k < 6; k++) begin
            exp_frame[k]     = BROADCAST_MAC[47 - 8*k -: 8];
            exp_frame[6 + k] = mac[47 - 8*k -: 8];
        end
        {exp_frame[12], exp_frame[13]} = ETHERTYPE_IPV4;
        exp_frame[14] = 8'h45;
        exp_frame[15] = 8'h00;
        {exp_frame[16], exp_frame[17]} = 16'd48;   // ip total length
        for (k = 18; k < 22; k++)
            exp_frame[k] = 8'h00;                   // id, flags, fragment
        exp_frame[22] = IPV4_TTL;
        exp_frame[23] = IPV4_PROTO_UDP;
        {exp_frame[24], exp_frame[25]} = 16'h0000;  // filled in below
        {exp_frame[26], exp_frame[27], exp_frame[28], exp_frame[29]} = LOCAL_IP;
        {exp_frame[30], exp_frame[31], exp_frame[32], exp_frame[33]} = HOST_IP;
        {exp_frame[34], exp_frame[35]} = dport + 16'd1;
        {exp_frame[36], exp_frame[37]} = dport;
        {exp_frame[38], exp_frame[39]} = 16'd28;   // udp length
        {exp_frame[40], exp_frame[41]} = 16'h0000;
        for (k = 0; k < SEQ_NUM_BYTES; k++)
            exp_frame[42 + k] = seq[8*k +: 8];      // lsb first
        sum = 32'd0;
        for (k = 14; k < 34; k += 2)
            sum = sum + {16'd0, exp_frame[k], exp_frame[k + 1]};
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        {exp_frame[24], exp_frame[25]} = ~sum[15:0];
        for (k = 0; k < PAYLOAD_BYTES; k++)
            exp_frame[HDR_BYTES + k] = sent_q[src].pop_front();
    endtask

    task automatic check_frame();
        udp_port_t dport;
        int        src;
        int        k;
        assert (rx_frame.size() == FRAME_BYTES)
            else report_mismatch("frame length", FRAME_BYTES, rx_frame.size());
        dport = {rx_frame[36], rx_frame[37]};
        src   = (dport == VC_TX_PORT) ? SRC_VC : SRC_RB;
        assert (dport == RB_TX_PORT || dport == VC_TX_PORT)
            else report_failure("frame carries an unknown destination port");
        assert (sent_q[src].size() >= PAYLOAD_BYTES)
            else report_failure("frame arrived before its payload was taken");
        build_expected(src, exp_seq[src]);
        for (k = 0; k < FRAME_BYTES; k++) begin
            assert (rx_frame[k] == exp_frame[k])
                else report_mismatch($sformatf("%s frame %0d byte %0d", src_name(src),
                                               exp_seq[src], k), exp_frame[k], rx_frame[k]);
        end
        exp_seq[src] = exp_seq[src] + 1;
        src_order.push_back(src);
        rx_frame.delete();
    endtask

    // collects a byte whenever the mac reads one
    always @(negedge i_tx_clk125) begin
        if (!i_reset && fifoavail && i_mac_tx_macread) begin
            rx_frame.push_back(fifodata);
            if (fifoeof)
                check_frame();
            else
                assert (rx_frame.size() < FRAME_BYTES)
                    else report_failure("frame ran past its length without eof");
        end
    end

    always @(negedge i_tx_clk125) begin
        assert (eth_tx_top_i.eth_tx_assert_i.fail_cnt == 0)
            else report_failure("a protocol assertion on the DUT ports fired");
    end

    // holds start until ack and counts the refused cycles
    task automatic request_start(input int src, input int release_after, output int refused);
        int waited;
        refused     = 0;
        waited      = 0;
        start[src]  = 1'b1;
        forever begin
            @(posedge i_tx_clk125);
            #2;
            if (start_ack[src])
                break;
            refused++;
            waited++;
            if (release_after > 0 && refused == release_after)
                i_mac_tx_macread = 1'b1;   // let the buffer drain
            assert (waited < TIMEOUT_CYCLES)
                else report_failure($sformatf("%s start never acknowledged", src_name(src)));
        end
        start[src]   = 1'b0;
        exp_ovf[src] = exp_ovf[src] + cntr_t'(refused);
        assert (ovf_cntr[src] == exp_ovf[src])
            else report_mismatch($sformatf("%s overflow counter", src_name(src)),
                                 exp_ovf[src], ovf_cntr[src]);
    endtask

    task automatic send_payload(input int src);
        int taken;
        int waited;
        taken  = 0;
        waited = 0;
        while (taken < PAYLOAD_BYTES) begin
            vld[src]  = (($random(seed) & 3) != 0);   // about one idle cycle in four
            data[src] = byte_t'($random(seed));
            @(negedge i_tx_clk125);
            if (data_rd[src]) begin
                sent_q[src].push_back(data[src]);
                taken++;
            end
            @(posedge i_tx_clk125);
            #2;
            waited++;
            assert (waited < TIMEOUT_CYCLES)
                else report_failure($sformatf("%s payload not taken", src_name(src)));
        end
        vld[src] = 1'b0;
    endtask

    task automatic wait_done(input int src);
        int waited;
        waited = 0;
        while (!done[src]) begin
            @(posedge i_tx_clk125);
            #2;
            waited++;
            assert (waited < TIMEOUT_CYCLES)
                else report_failure($sformatf("%s done never pulsed", src_name(src)));
        end
    endtask

    task automatic send_frame(input int src, input int release_after);
        int refused;
        request_start(src, release_after, refused);
        if (release_after > 0)
            assert (refused >= release_after)
                else report_mismatch("refused starts while full", release_after, refused);
        send_payload(src);
        wait_done(src);
    endtask

    task automatic wait_frames(input int total);
        int waited;
        waited = 0;
        while (src_order.size() < total) begin
            @(posedge i_tx_clk125);
            #2;
            waited++;
            assert (waited < TIMEOUT_CYCLES)
                else report_failure($sformatf("only %0d of %0d frames reached the mac",
                                              src_order.size(), total));
        end
    endtask

    initial begin
        int n;
        seed             = 92;
        i_reset          = 1'b1;
        start            = '0;
        vld              = '0;
        data[SRC_RB]     = '0;
        data[SRC_VC]     = '0;
        i_mac_tx_macread = 1'b0;
        for (n = 0; n < NUM_SOURCES; n++) begin
            exp_seq[n]     = '0;
            exp_ovf[n]     = '0;
        end
        test_name = "reset";
        repeat (5) @(posedge i_tx_clk125);
        #2;
        i_reset = 1'b0;
        @(negedge i_tx_clk125);
        assert ({start_ack, done, data_rd, fifoavail, fifoeof} == '0)
            else report_mismatch("strobes after reset", 0, {start_ack, done, data_rd,
                                                             fifoavail, fifoeof});
        assert (ovf_cntr[SRC_RB] == '0 && ovf_cntr[SRC_VC] == '0)
            else report_failure("overflow counters not cleared by reset");
        @(posedge i_tx_clk125);
        #2;

        test_name        = "frames in turn";
        i_mac_tx_macread = 1'b1;
        for (n = 0; n < 3; n++) begin
            send_frame(SRC_RB, 0);
            send_frame(SRC_VC, 0);
        end
        wait_frames(6);

        test_name        = "round robin";
        i_mac_tx_macread = 1'b0;   // both sources pile up
        send_frame(SRC_RB, 0);
        send_frame(SRC_VC, 0);
        send_frame(SRC_RB, 0);
        send_frame(SRC_VC, 0);
        i_mac_tx_macread = 1'b1;
        wait_frames(10);
        for (n = 7; n < 10; n++)
            assert (src_order[n] != src_order[n - 1])
                else report_mismatch($sformatf("source of frame %0d", n),
                                     1 - src_order[n - 1], src_order[n]);

        test_name        = "buffer overflow";
        i_mac_tx_macread = 1'b0;
        send_frame(SRC_RB, 0);
        send_frame(SRC_RB, 0);
        send_frame(SRC_RB, 20);    // refused until the mac drains one frame
        wait_frames(13);

        test_name = "end of run";
        @(posedge i_tx_clk125);
        #2;
        assert (!fifoavail)
            else report_failure("the mac port offers another frame after the last one");
        if (eth_tx_top_i.eth_tx_assert_i.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "protocol assertions fired");
        end
    end

endmodule

/* vlog.f */
common/eth_pkg.sv
common/stream_pkg.sv
udp_tx/udp_header_gen.sv
verilog/frame_fifo.sv
udp_tx/udp_packetizer.sv
mac_tx/mac_tx_arbiter.sv
verilog/eth_tx_top.sv
tb/eth_tx_assert.sv
tb/eth_tx_tb.sv

/* Makefile */
TOP = eth_tx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
